//--- alu.sv
// 32-bit integer ALU without overflow detection; slt compares as signed
`timescale 1ns/1ps
`include "mips_config.svh"

module alu (
  input  logic [`DATA_WIDTH-1:0] a,
  input  logic [`DATA_WIDTH-1:0] b,
  input  mipsPkg::aluOpT         op,
  output logic [`DATA_WIDTH-1:0] result,
  output logic                   zero
);

  import mipsPkg::*;

  // ==============================
  // operation select
  // ==============================
  always_comb begin
    case (op)
      aluAdd: begin
        result = a + b;
      end
      aluSub: begin
        // also feeds the beq compare
        result = a - b;
      end
      aluAnd: begin
        result = a & b;
      end
      aluOr: begin
        result = a | b;
      end
      aluSlt: begin
        // one in bit 0, rest cleared
        result = '0;
        result[0] = $signed(a) < $signed(b);
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // ==============================
  // flags
  // ==============================

  // high on any zero result, not only for sub
  assign zero = (result == '0);

endmodule

//--- controlUnit.sv
// combined main and ALU decoder; unknown opcodes and function codes decode to a no-op
`timescale 1ns/1ps
`include "mips_config.svh"

module controlUnit (
  input  mipsPkg::opcodeT opcode,
  input  mipsPkg::functT  funct,
  input  logic            rst,
  output logic            regDst,
  output logic            aluSrc,
  output logic            memToReg,
  output logic            regWrite,
  output logic            memWrite,
  output logic            branch,
  output logic            jump,
  output logic            link,
  output mipsPkg::aluOpT  aluOp
);

  import mipsPkg::*;

  always_comb begin
    // default is a no-op with pc + 4
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    aluOp    = aluAdd;

    case (opcode)
      opR: begin
        // only the five known function codes write rd
        case (funct)
          fnAdd: aluOp = aluAdd;
          fnSub: aluOp = aluSub;
          fnAnd: aluOp = aluAnd;
          fnOr:  aluOp = aluOr;
          fnSlt: aluOp = aluSlt;
          default: aluOp = aluAdd;
        endcase
        regDst   = funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt};
        regWrite = regDst;
      end
      opLw: begin
        // rs + imm, data back into rt
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      opBeq: begin
        // zero flag of rs - rt decides
        aluOp  = aluSub;
        branch = 1'b1;
      end
      opJ: begin
        jump = 1'b1;
      end
      opJal: begin
        // pc + 8 into r31
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        // unknown opcode keeps defaults
        aluOp = aluAdd;
      end
    endcase

    // no writes while the core is held in reset
    if (!rst) begin
      memWrite = 1'b0;
      regWrite = 1'b0;
    end
  end

endmodule

//--- mipsCore.sv
// single-cycle core top; imem and dmem are external with combinational reads, one instr per clk
`timescale 1ns/1ps
`include "mips_config.svh"

module mipsCore (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [31:0]                instr,
  input  logic [`DATA_WIDTH-1:0]     dataReadData,
  output logic [31:0]                instrAddr,
  output logic [`DMEM_ADDR_WIDTH-1:0] dataAddr,
  output logic [`DATA_WIDTH-1:0]     dataWriteData,
  output logic                       memWriteN,
  output logic [`DATA_WIDTH-1:0]     rfWriteData
);

  import mipsPkg::*;

  // instruction fields
  opcodeT      opcode;
  functT       funct;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [15:0] imm;
  logic [25:0] jumpIndex;

  // immediate forms
  logic [`DATA_WIDTH-1:0] signExtImm;
  logic [`DATA_WIDTH-1:0] branchOffset;

  // decoder outputs
  logic  regDst;
  logic  aluSrc;
  logic  memToReg;
  logic  regWrite;
  logic  memWrite;
  logic  branch;
  logic  jump;
  logic  link;
  aluOpT aluOp;

  // datapath
  logic [`DATA_WIDTH-1:0] readData1;
  logic [`DATA_WIDTH-1:0] readData2;
  logic [`DATA_WIDTH-1:0] aluB;
  logic [`DATA_WIDTH-1:0] aluResult;
  logic                   aluZero;
  logic                   takeBranch;
  logic [4:0]             writeAddr;
  logic [`DATA_WIDTH-1:0] writeData;
  logic [`DATA_WIDTH-1:0] pc;
  logic [`DATA_WIDTH-1:0] pcPlus8;

  // ==============================
  // field split
  // ==============================

  // codes outside the enums decode as no-op
  assign opcode    = opcodeT'(instr[31:26]);
  assign funct     = functT'(instr[5:0]);
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign imm       = instr[15:0];
  assign jumpIndex = instr[25:0];

  assign signExtImm   = {{(`DATA_WIDTH-16){imm[15]}}, imm};
  // word offset to byte offset
  assign branchOffset = {signExtImm[`DATA_WIDTH-3:0], 2'b00};

  controlUnit controlUnit_i (
    .opcode   (opcode),
    .funct    (funct),
    .rst      (rst),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .memWrite (memWrite),
    .branch   (branch),
    .jump     (jump),
    .link     (link),
    .aluOp    (aluOp)
  );

  // ==============================
  // register file and ALU
  // ==============================

  // destination is rt for lw, rd for R-type, r31 for jal
  assign writeAddr = link ? 5'd31 : (regDst ? rd : rt);

  registerFile registerFile_i (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (regWrite),
    .readAddr1 (rs),
    .readAddr2 (rt),
    .writeAddr (writeAddr),
    .writeData (writeData),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  // immediate for lw and sw
  assign aluB = aluSrc ? signExtImm : readData2;

  alu alu_i (
    .a      (readData1),
    .b      (aluB),
    .op     (aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // ==============================
  // write-back and next pc
  // ==============================
  assign writeData  = link ? pcPlus8 : (memToReg ? dataReadData : aluResult);
  // beq taken when rs - rt is zero
  assign takeBranch = branch & aluZero;

  programCounter programCounter_i (
    .clk          (clk),
    .rst          (rst),
    .takeBranch   (takeBranch),
    .jump         (jump),
    .branchOffset (branchOffset),
    .jumpIndex    (jumpIndex),
    .pc           (pc),
    .pcPlus8      (pcPlus8)
  );

  // external ports
  assign instrAddr     = pc;
  // byte address to word address, wraps at the memory size
  assign dataAddr      = aluResult[`DMEM_ADDR_WIDTH+1:2];
  assign dataWriteData = readData2;
  assign memWriteN     = ~memWrite;
  assign rfWriteData   = writeData;

endmodule

//--- mipsPkg.sv
// decode encodings for the supported subset only; any other code is a no-op in the core
package mipsPkg;

  // ==============================
  // primary opcodes, instr[31:26]
  // ==============================
  typedef enum logic [5:0] {
    // all R-type share opcode zero
    opR   = 6'b000000,
    // absolute jump inside the 256 MB region
    opJ   = 6'b000010,
    // jump and link into register 31
    opJal = 6'b000011,
    // branch on equal, pc relative
    opBeq = 6'b000100,
    // word load
    opLw  = 6'b100011,
    // word store
    opSw  = 6'b101011
  } opcodeT;

  // ==============================
  // R-type function codes, instr[5:0]
  // ==============================
  typedef enum logic [5:0] {
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnOr  = 6'b100101,
    // signed compare
    fnSlt = 6'b101010
  } functT;

  // ==============================
  // internal ALU operation select
  // ==============================
  typedef enum logic [2:0] {
    // also address calc for lw and sw
    aluAdd = 3'd0,
    // also compare for beq
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    // set one on signed less-than
    aluSlt = 3'd4
  } aluOpT;

endpackage

//--- mips_config.svh
// core sizing macros; 32-bit words only, data memory is word addressed and wraps at 128 words
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// ==============================
// datapath
// ==============================

// width of one data word and of the PC
`define DATA_WIDTH 32

// general purpose registers, index width is log2 of this
`define REG_COUNT 32

// ==============================
// memory and reset
// ==============================

// word address into the external data memory
`define DMEM_ADDR_WIDTH 7
// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- programCounter.sv
// PC register and next-PC select; jump beats branch, no jr and no exception vectors
`timescale 1ns/1ps
`include "mips_config.svh"

module programCounter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   takeBranch,
  input  logic                   jump,
  input  logic [`DATA_WIDTH-1:0] branchOffset,
  input  logic [25:0]            jumpIndex,
  output logic [`DATA_WIDTH-1:0] pc,
  output logic [`DATA_WIDTH-1:0] pcPlus8
);

  logic [`DATA_WIDTH-1:0] pcPlus4;
  logic [`DATA_WIDTH-1:0] branchTarget;
  logic [`DATA_WIDTH-1:0] jumpTarget;
  logic [`DATA_WIDTH-1:0] nextPc;

  // ==============================
  // candidate targets
  // ==============================
  assign pcPlus4 = pc + `DATA_WIDTH'd4;
  // return address for jal
  assign pcPlus8 = pc + `DATA_WIDTH'd8;

  // offset is already sign extended and shifted by two
  assign branchTarget = pcPlus4 + branchOffset;

  // upper nibble kept from pc + 4
  assign jumpTarget = {pcPlus4[`DATA_WIDTH-1 -: 4], jumpIndex, 2'b00};

  // priority select
  always_comb begin
    if (jump) begin
      nextPc = jumpTarget;
    end else if (takeBranch) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // ==============================
  // pc register
  // ==============================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `RESET_PC;
    end else begin
      // one instruction per edge
      pc <= nextPc;
    end
  end

endmodule

//--- registerFile.sv
// 2 read / 1 write register array; write lands on the rising edge, index 0 is always zero
`timescale 1ns/1ps
`include "mips_config.svh"

module registerFile (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           writeEn,
  input  logic [$clog2(`REG_COUNT)-1:0]  readAddr1,
  input  logic [$clog2(`REG_COUNT)-1:0]  readAddr2,
  input  logic [$clog2(`REG_COUNT)-1:0]  writeAddr,
  input  logic [`DATA_WIDTH-1:0]         writeData,
  output logic [`DATA_WIDTH-1:0]         readData1,
  output logic [`DATA_WIDTH-1:0]         readData2
);

  // register storage
  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  // ==============================
  // write port
  // ==============================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // whole file cleared on reset
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // writes to r0 dropped
      regs[writeAddr] <= writeData;
    end
  end

  // ==============================
  // read ports
  // ==============================

  // combinational, r0 forced to zero
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

//--- run.sh
#!/usr/bin/env bash
# compile and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tbMipsCore

# keep going on a failing simulator exit so the output is still shown
output="$(./obj_dir/VtbMipsCore 2>&1 || true)"
echo "$output"

if grep -qxF ">>> PASS" <<< "$output"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tbClock.sv
// testbench clock and reset source; reset is released by a nonblocking write on a rising edge
`timescale 1ns/1ps

module tbClock #(
  parameter int periodNs    = 4,
  parameter int resetCycles = 5
) (
  output logic clk,
  output logic rst
);

  // free running clock
  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // active low reset held for the first rising edges
  initial begin
    rst = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b1;
  end

endmodule

//--- tbMipsModel.svh
// included inside the testbench module body; $urandom must be seeded before randomInstr is called
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// ==============================
// reference model state
// ==============================
logic [`DATA_WIDTH-1:0] modelRegs [`REG_COUNT];
logic [`DATA_WIDTH-1:0] modelPc;
logic [`DATA_WIDTH-1:0] modelMem [1 << `DMEM_ADDR_WIDTH];

// expected DUT behavior for the instruction just stepped
bit                         expRegWrite;
logic [`DATA_WIDTH-1:0]     expWb;
bit                         expStore;
bit                         expMemAccess;
logic [`DMEM_ADDR_WIDTH-1:0] expAddr;
logic [`DATA_WIDTH-1:0]     expStoreData;

// one instruction at instruction level, straight from the ISA rules
task automatic stepModel(input logic [31:0] ins);
  logic [`DATA_WIDTH-1:0] a;
  logic [`DATA_WIDTH-1:0] b;
  logic [`DATA_WIDTH-1:0] simm;
  logic [`DATA_WIDTH-1:0] effAddr;
  logic [`DATA_WIDTH-1:0] pcPlus4;
  logic [`DATA_WIDTH-1:0] nextPc;
  logic [4:0]             dest;
  a       = modelRegs[ins[25:21]];
  b       = modelRegs[ins[20:16]];
  simm    = {{(`DATA_WIDTH-16){ins[15]}}, ins[15:0]};
  effAddr = a + simm;
  pcPlus4 = modelPc + 4;
  nextPc  = pcPlus4;
  dest    = 5'd0;
  expRegWrite  = 1'b0;
  expStore     = 1'b0;
  expMemAccess = 1'b0;
  expWb        = '0;
  expStoreData = '0;
  expAddr      = effAddr[`DMEM_ADDR_WIDTH+1:2];
  case (ins[31:26])
    6'h00: begin
      dest        = ins[15:11];
      expRegWrite = 1'b1;
      case (ins[5:0])
        6'h20: expWb = a + b;
        6'h22: expWb = a - b;
        6'h24: expWb = a & b;
        6'h25: expWb = a | b;
        6'h2a: expWb = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        // unknown funct is a no-op
        default: expRegWrite = 1'b0;
      endcase
    end
    6'h23: begin
      // lw, word address wraps at memory size
      dest         = ins[20:16];
      expRegWrite  = 1'b1;
      expMemAccess = 1'b1;
      expWb        = modelMem[expAddr];
    end
    6'h2b: begin
      expStore         = 1'b1;
      expMemAccess     = 1'b1;
      expStoreData     = b;
      modelMem[expAddr] = b;
    end
    6'h04: begin
      if (a == b) begin
        nextPc = pcPlus4 + (simm << 2);
      end
    end
    6'h02: begin
      nextPc = {pcPlus4[31:28], ins[25:0], 2'b00};
    end
    6'h03: begin
      // jal links the address after the delay slot position
      nextPc      = {pcPlus4[31:28], ins[25:0], 2'b00};
      dest        = 5'd31;
      expRegWrite = 1'b1;
      expWb       = modelPc + 8;
    end
    default: begin
      // anything else just falls through
    end
  endcase
  if (expRegWrite && dest != 5'd0) begin
    modelRegs[dest] = expWb;
  end
  modelPc = nextPc;
endtask

// ==============================
// random program
// ==============================
function automatic logic [31:0] randomInstr();
  int unsigned pick;
  int          off;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [5:0]  fn;
  logic [5:0]  op;
  logic [15:0] imm;
  pick = $urandom_range(0, 99);
  rs   = 5'($urandom_range(0, 31));
  rt   = 5'($urandom_range(0, 31));
  rd   = 5'($urandom_range(0, 31));
  // word aligned offsets of both signs
  imm  = 16'($urandom_range(0, 255) * 4) - 16'd512;
  if (pick < 40) begin
    case ($urandom_range(0, 5))
      0: fn = 6'h20;
      1: fn = 6'h22;
      2: fn = 6'h24;
      3: fn = 6'h25;
      4: fn = 6'h2a;
      // addu, not supported
      default: fn = 6'h21;
    endcase
    return {6'h00, rs, rt, rd, 5'd0, fn};
  end else if (pick < 54) begin
    return {6'h23, rs, rt, imm};
  end else if (pick < 68) begin
    return {6'h2b, rs, rt, imm};
  end else if (pick < 80) begin
    // small offsets, -1 would spin on itself
    off = int'($urandom_range(0, 11)) - 4;
    if (off == -1) begin
      off = 3;
    end
    return {6'h04, rs, rt, 16'(off)};
  end else if (pick < 88) begin
    return {6'h02, 26'($urandom_range(0, 255))};
  end else if (pick < 94) begin
    return {6'h03, 26'($urandom_range(0, 255))};
  end
  // addi, lui and an unused code
  case ($urandom_range(0, 2))
    0: op = 6'h08;
    1: op = 6'h0f;
    default: op = 6'h3f;
  endcase
  return {op, rs, rt, 16'($urandom_range(0, 65535))};
endfunction

`endif

//--- tbMipsCore.sv
// random program testbench; stops at the first mismatch, runs a fixed number of instructions
`timescale 1ns/1ps
`include "mips_config.svh"

module tbMipsCore;

  localparam int numCycles = 2000;
  localparam int timeoutNs = (numCycles + 5 + 20) * 4;
  localparam int dmemWords = 1 << `DMEM_ADDR_WIDTH;
  localparam int seed      = 99435;

  logic                        clk;
  logic                        rst;
  logic [31:0]                 instr;
  logic [`DATA_WIDTH-1:0]      dataReadData;
  logic [31:0]                 instrAddr;
  logic [`DMEM_ADDR_WIDTH-1:0] dataAddr;
  logic [`DATA_WIDTH-1:0]      dataWriteData;
  logic                        memWriteN;
  logic [`DATA_WIDTH-1:0]      rfWriteData;

  // external memories of the core
  logic [31:0]            imem [256];
  logic [`DATA_WIDTH-1:0] dmem [dmemWords];

  `include "tbMipsModel.svh"

  tbClock clockGen_i (
    .clk (clk),
    .rst (rst)
  );

  mipsCore dut_i (
    .clk           (clk),
    .rst           (rst),
    .instr         (instr),
    .dataReadData  (dataReadData),
    .instrAddr     (instrAddr),
    .dataAddr      (dataAddr),
    .dataWriteData (dataWriteData),
    .memWriteN     (memWriteN),
    .rfWriteData   (rfWriteData)
  );

  // combinational read ports
  assign instr        = imem[instrAddr[9:2]];
  assign dataReadData = dmem[dataAddr];

  // ==============================
  // checks
  // ==============================
  task automatic checkEqual(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
    if (got !== expected) begin
      $display("** Error at %0d ns: %s, got %h, expected %h", $time, what, got, expected);
      $display(">>> FAIL");
      $fatal(1, "mismatch, run stopped");
    end
  endtask

  // compare one executed instruction against the model
  task automatic verifyStep();
    logic [31:0] ins;
    logic [31:0] pcNow;
    pcNow = modelPc;
    ins   = imem[pcNow[9:2]];
    checkEqual(instrAddr, pcNow, "instrAddr vs model pc");
    stepModel(ins);
    checkEqual(32'(memWriteN), expStore ? 32'd0 : 32'd1,
               $sformatf("memWriteN for %h at pc %h", ins, pcNow));
    if (expRegWrite) begin
      checkEqual(rfWriteData, expWb, $sformatf("write-back for %h at pc %h", ins, pcNow));
    end
    if (expMemAccess) begin
      checkEqual(32'(dataAddr), 32'(expAddr), $sformatf("dataAddr for %h", ins));
    end
    if (expStore) begin
      checkEqual(dataWriteData, expStoreData, $sformatf("store data for %h", ins));
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    logic [`DATA_WIDTH-1:0] word;
    void'($urandom(seed));
    for (int i = 0; i < 256; i++) begin
      imem[i] = randomInstr();
    end
    // store at the reset pc so the write hold in reset is exercised
    imem[8'(`RESET_PC >> 2)] = {6'h2b, 5'd0, 5'd0, 16'd0};
    // random data with a model copy
    for (int i = 0; i < dmemWords; i++) begin
      word = $urandom();
      dmem[i] <= word;
      modelMem[i] = word;
    end
    for (int i = 0; i < `REG_COUNT; i++) begin
      modelRegs[i] = '0;
    end
    modelPc = `RESET_PC;
    // stores land on the rising edge
    fork
      forever begin
        @(posedge clk);
        if (rst && !memWriteN) begin
          dmem[dataAddr] <= dataWriteData;
        end
      end
    join_none
    // sample on falling edges once outputs settle
    @(negedge clk);
    while (!rst) begin
      checkEqual(instrAddr, `RESET_PC, "instrAddr during reset");
      checkEqual(32'(memWriteN), 32'd1, "memWriteN during reset");
      @(negedge clk);
    end
    repeat (numCycles) begin
      verifyStep();
      @(negedge clk);
    end
    $display(">>> PASS");
    $finish;
  end

  // watchdog
  initial begin
    #(timeoutNs);
    $display("timeout: run did not finish within %0d ns", timeoutNs);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- vlog.f
+incdir+.
mipsPkg.sv
controlUnit.sv
alu.sv
registerFile.sv
programCounter.sv
mipsCore.sv
tbClock.sv
tbMipsCore.sv
